//--- Bender.yml
package:
  name: conv1

sources:
  - design/conv1_pkg.sv
  - design/conv1_ifs.sv
  - design/conv1_weight_regs.sv
  - design/conv1_line_buffer.sv
  - design/conv1_filter_array.sv
  - design/conv1_max_pool.sv
  - design/conv1_top.sv
  - target: simulation
    files:
      - verification/conv1_assertions.sv
      - verification/conv1_tb.sv

//--- design/conv1_filter_array.sv
// conv1_filter_array: two-stage multiply-accumulate for both filters with rectified output
`default_nettype none

module conv1_filter_array (
    input  logic                clk_i,
    input  logic                reset_i,
    input  conv1_pkg::weight_t [conv1_pkg::NUM_FILT-1:0][conv1_pkg::NUM_TAPS-1:0] weights_i,
    window_if.dst               win,
    act_if.src                  act
);

    // stage one, one product per tap and filter
    conv1_pkg::sum_t [conv1_pkg::NUM_FILT-1:0][conv1_pkg::NUM_TAPS-1:0] prod_q;
    logic                                                               valid_q;
    conv1_pkg::coord_t                                                  row_q;
    conv1_pkg::coord_t                                                  col_q;

    // stage two adder tree input
    conv1_pkg::sum_t [conv1_pkg::NUM_FILT-1:0]                          sum_c;

    // valid flag for stage one
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= win.win_valid;
        end
    end

    // products, pixel zero-extended so it stays positive
    always_ff @(posedge clk_i) begin
        if (win.win_valid) begin
            for (int f = 0; f < conv1_pkg::NUM_FILT; f++) begin
                for (int t = 0; t < conv1_pkg::NUM_TAPS; t++) begin
                    prod_q[f][t] <= conv1_pkg::sum_t'($signed({1'b0, win.win_pixels[t]})) *
                                    conv1_pkg::sum_t'(weights_i[f][t]);
                end
            end
            row_q <= win.win_row;
            col_q <= win.win_col;
        end
    end

    // nine-tap sum per filter
    // cannot overflow sum_t for 8-bit operands
    always_comb begin
        for (int f = 0; f < conv1_pkg::NUM_FILT; f++) begin
            sum_c[f] = '0;
            for (int t = 0; t < conv1_pkg::NUM_TAPS; t++) begin
                sum_c[f] = sum_c[f] + prod_q[f][t];
            end
        end
    end

    // valid flag for stage two
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            act.act_valid <= 1'b0;
        end else begin
            act.act_valid <= valid_q;
        end
    end

    // rectifier, negative sums go to zero
    always_ff @(posedge clk_i) begin
        if (valid_q) begin
            for (int f = 0; f < conv1_pkg::NUM_FILT; f++) begin
                if (sum_c[f] < 0) begin
                    act.act_data[f] <= '0;
                end else begin
                    act.act_data[f] <= conv1_pkg::act_t'(sum_c[f]);
                end
            end
            act.act_row <= row_q;
            act.act_col <= col_q;
        end
    end

endmodule

`default_nettype wire

//--- design/conv1_ifs.sv
// window_if and act_if: window and activation streams with their src and dst modports
`default_nettype none

// 3x3 window from line buffer to filter array
interface window_if;

    // one-cycle strobe per complete window
    logic                                               win_valid;
    // tap order row-major, tap 0 oldest
    conv1_pkg::pixel_t [conv1_pkg::NUM_TAPS-1:0]        win_pixels;
    // map position of the window
    conv1_pkg::coord_t                                  win_row;
    conv1_pkg::coord_t                                  win_col;

    modport src (
        output win_valid,
        output win_pixels,
        output win_row,
        output win_col
    );

    modport dst (
        input  win_valid,
        input  win_pixels,
        input  win_row,
        input  win_col
    );

endinterface

// rectified activations from filter array to pool
interface act_if;

    logic                                               act_valid;
    // one activation per filter
    conv1_pkg::act_t [conv1_pkg::NUM_FILT-1:0]          act_data;
    conv1_pkg::coord_t                                  act_row;
    conv1_pkg::coord_t                                  act_col;

    modport src (
        output act_valid,
        output act_data,
        output act_row,
        output act_col
    );

    modport dst (
        input  act_valid,
        input  act_data,
        input  act_row,
        input  act_col
    );

endinterface

`default_nettype wire

//--- design/conv1_line_buffer.sv
// conv1_line_buffer: raster position counters, two row delay lines and the 3x3 window
`default_nettype none

module conv1_line_buffer (
    input  logic                clk_i,
    input  logic                reset_i,
    input  logic                pixel_valid_i,
    input  conv1_pkg::pixel_t   pixel_i,
    input  logic                sof_i,
    window_if.src               win
);

    // position of the next pixel
    conv1_pkg::coord_t row_q;
    conv1_pkg::coord_t col_q;
    // position of the current pixel, sof forces (0,0)
    conv1_pkg::coord_t row_c;
    conv1_pkg::coord_t col_c;
    // window holds a full 3x3 block after this pixel
    logic              full_c;

    // row delay lines, one row apart
    conv1_pkg::pixel_t line1_q [conv1_pkg::FRAME_W];
    conv1_pkg::pixel_t line2_q [conv1_pkg::FRAME_W];

    always_comb begin
        row_c  = sof_i ? '0 : row_q;
        col_c  = sof_i ? '0 : col_q;
        full_c = (row_c >= conv1_pkg::coord_t'(conv1_pkg::KERNEL - 1)) &&
                 (col_c >= conv1_pkg::coord_t'(conv1_pkg::KERNEL - 1));
    end

    // raster counters, advance on strobes only
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            row_q         <= '0;
            col_q         <= '0;
            win.win_valid <= 1'b0;
        end else begin
            win.win_valid <= pixel_valid_i && full_c;
            if (pixel_valid_i) begin
                if (col_c == conv1_pkg::coord_t'(conv1_pkg::FRAME_W - 1)) begin
                    col_q <= '0;
                    // wrap at end of frame
                    if (row_c == conv1_pkg::coord_t'(conv1_pkg::FRAME_H - 1)) begin
                        row_q <= '0;
                    end else begin
                        row_q <= row_c + 1'b1;
                    end
                end else begin
                    col_q <= col_c + 1'b1;
                    row_q <= row_c;
                end
            end
        end
    end

    // delay lines and window shift together
    always_ff @(posedge clk_i) begin
        if (pixel_valid_i) begin
            line1_q[0] <= pixel_i;
            line2_q[0] <= line1_q[conv1_pkg::FRAME_W-1];
            for (int i = 1; i < conv1_pkg::FRAME_W; i++) begin
                line1_q[i] <= line1_q[i-1];
                line2_q[i] <= line2_q[i-1];
            end

            // older columns move left
            for (int r = 0; r < conv1_pkg::KERNEL; r++) begin
                for (int c = 0; c < conv1_pkg::KERNEL - 1; c++) begin
                    win.win_pixels[r*conv1_pkg::KERNEL+c] <=
                        win.win_pixels[r*conv1_pkg::KERNEL+c+1];
                end
            end

            // newest column enters on the right
            // top row is two rows back, bottom row is the live pixel
            win.win_pixels[conv1_pkg::KERNEL-1]   <= line2_q[conv1_pkg::FRAME_W-1];
            win.win_pixels[2*conv1_pkg::KERNEL-1] <= line1_q[conv1_pkg::FRAME_W-1];
            win.win_pixels[conv1_pkg::NUM_TAPS-1] <= pixel_i;

            // window's top-left corner as map position
            win.win_row <= row_c - conv1_pkg::coord_t'(conv1_pkg::KERNEL - 1);
            win.win_col <= col_c - conv1_pkg::coord_t'(conv1_pkg::KERNEL - 1);
        end
    end

endmodule

`default_nettype wire

//--- design/conv1_max_pool.sv
// conv1_max_pool: 2x2 stride-2 max pool with a half-row buffer of partial maxima
`default_nettype none

module conv1_max_pool (
    input  logic                                        clk_i,
    input  logic                                        reset_i,
    act_if.dst                                          act,
    output logic                                        pool_valid_o,
    output conv1_pkg::act_t [conv1_pkg::NUM_FILT-1:0]   pool_data_o
);

    // first value of the current column pair
    conv1_pkg::act_t [conv1_pkg::NUM_FILT-1:0]  pair_q;
    // column-pair maxima of the last even row
    conv1_pkg::act_t [conv1_pkg::NUM_FILT-1:0]  half_q [conv1_pkg::POOL_W];

    // pooling window index along the row
    logic [$bits(conv1_pkg::coord_t)-2:0]       slot_c;
    logic                                       odd_row_c;
    logic                                       odd_col_c;

    function automatic conv1_pkg::act_t max2(
        input conv1_pkg::act_t a,
        input conv1_pkg::act_t b
    );
        return (a > b) ? a : b;
    endfunction

    always_comb begin
        slot_c    = act.act_col[$bits(conv1_pkg::coord_t)-1:1];
        odd_row_c = act.act_row[0];
        odd_col_c = act.act_col[0];
    end

    // strobe only when a 2x2 block closes
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            pool_valid_o <= 1'b0;
        end else begin
            pool_valid_o <= act.act_valid && odd_row_c && odd_col_c;
        end
    end

    always_ff @(posedge clk_i) begin
        if (act.act_valid) begin
            for (int f = 0; f < conv1_pkg::NUM_FILT; f++) begin
                if (!odd_col_c) begin
                    // left column, odd rows fold in the stored upper pair
                    if (odd_row_c) begin
                        pair_q[f] <= max2(half_q[slot_c][f], act.act_data[f]);
                    end else begin
                        pair_q[f] <= act.act_data[f];
                    end
                end else if (!odd_row_c) begin
                    // upper pair done, park it for the next row
                    half_q[slot_c][f] <= max2(pair_q[f], act.act_data[f]);
                end else begin
                    // last of four
                    pool_data_o[f] <= max2(pair_q[f], act.act_data[f]);
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- design/conv1_pkg.sv
// conv1_pkg: frame, kernel and width constants plus pixel, weight, sum and activation types
`default_nettype none

package conv1_pkg;

    // input frame geometry, raster order
    localparam int FRAME_W = 8;
    localparam int FRAME_H = 8;

    // square kernel and filter count
    localparam int KERNEL   = 3;
    localparam int NUM_TAPS = KERNEL * KERNEL;
    localparam int NUM_FILT = 2;

    // valid convolution map, then stride-2 pooling
    localparam int CONV_W = FRAME_W - KERNEL + 1;
    localparam int POOL_W = CONV_W / 2;

    // datapath widths
    localparam int PIXEL_W  = 8;
    localparam int WEIGHT_W = 8;
    localparam int ADDR_W   = 5;
    localparam int COORD_W  = 3;
    // 9-bit pixel times 8-bit weight, plus 4 bits of growth over nine taps
    localparam int SUM_W    = 21;
    // rectified sum drops the sign bit
    localparam int ACT_W    = SUM_W - 1;

    // unsigned input pixel
    typedef logic [PIXEL_W-1:0] pixel_t;

    // signed kernel coefficient
    typedef logic signed [WEIGHT_W-1:0] weight_t;

    // filter * NUM_TAPS + tap, tap = row * KERNEL + col
    // row 0 / col 0 is the oldest pixel of the window
    typedef logic [ADDR_W-1:0] wght_addr_t;

    // row or column index, image or map
    typedef logic [COORD_W-1:0] coord_t;

    // signed accumulator, also holds single products
    typedef logic signed [SUM_W-1:0] sum_t;

    // activation after clamping negatives
    typedef logic [ACT_W-1:0] act_t;

endpackage

`default_nettype wire

//--- design/conv1_top.sv
// conv1_top: weight store, line buffer, filter array and max pool wired to plain ports
`default_nettype none

module conv1_top (
    input  logic                                        clk_i,
    input  logic                                        reset_i,

    // pixel stream, one pixel per strobe
    input  logic                                        pixel_valid_i,
    input  conv1_pkg::pixel_t                           pixel_i,
    input  logic                                        sof_i,

    // weight write port, used between frames only
    input  logic                                        wght_we_i,
    input  conv1_pkg::wght_addr_t                       wght_addr_i,
    input  conv1_pkg::weight_t                          wght_data_i,

    // pooled results, 9 per frame
    output logic                                        pool_valid_o,
    output conv1_pkg::act_t [conv1_pkg::NUM_FILT-1:0]   pool_data_o
);

    // kernels of both filters
    conv1_pkg::weight_t [conv1_pkg::NUM_FILT-1:0][conv1_pkg::NUM_TAPS-1:0] weights;

    // internal streams
    window_if win_bus ();
    act_if    act_bus ();

    conv1_weight_regs conv1_weight_regs_inst (
        .clk_i          (clk_i),
        .reset_i        (reset_i),
        .wght_we_i      (wght_we_i),
        .wght_addr_i    (wght_addr_i),
        .wght_data_i    (wght_data_i),
        .weights_o      (weights)
    );

    // pixel strobe -> window, 1 cycle
    conv1_line_buffer conv1_line_buffer_inst (
        .clk_i          (clk_i),
        .reset_i        (reset_i),
        .pixel_valid_i  (pixel_valid_i),
        .pixel_i        (pixel_i),
        .sof_i          (sof_i),
        .win            (win_bus.src)
    );

    // window -> activation, 2 cycles
    conv1_filter_array conv1_filter_array_inst (
        .clk_i          (clk_i),
        .reset_i        (reset_i),
        .weights_i      (weights),
        .win            (win_bus.dst),
        .act            (act_bus.src)
    );

    // activation -> pooled result, 1 cycle
    conv1_max_pool conv1_max_pool_inst (
        .clk_i          (clk_i),
        .reset_i        (reset_i),
        .act            (act_bus.dst),
        .pool_valid_o   (pool_valid_o),
        .pool_data_o    (pool_data_o)
    );

endmodule

`default_nettype wire

//--- design/conv1_weight_regs.sv
// conv1_weight_regs: register file holding the kernels of both filters
`default_nettype none

module conv1_weight_regs (
    input  logic                                        clk_i,
    input  logic                                        reset_i,
    input  logic                                        wght_we_i,
    input  conv1_pkg::wght_addr_t                       wght_addr_i,
    input  conv1_pkg::weight_t                          wght_data_i,
    output conv1_pkg::weight_t [conv1_pkg::NUM_FILT-1:0][conv1_pkg::NUM_TAPS-1:0] weights_o
);

    // one-hot select of the addressed weight
    logic [conv1_pkg::NUM_FILT-1:0][conv1_pkg::NUM_TAPS-1:0] hit_c;

    // address decode, filter-major
    // addresses past the last tap match nothing
    always_comb begin
        for (int f = 0; f < conv1_pkg::NUM_FILT; f++) begin
            for (int t = 0; t < conv1_pkg::NUM_TAPS; t++) begin
                hit_c[f][t] = wght_we_i &&
                    (wght_addr_i == conv1_pkg::wght_addr_t'(f * conv1_pkg::NUM_TAPS + t));
            end
        end
    end

    // one weight replaced per strobe
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            weights_o <= '0;
        end else begin
            for (int f = 0; f < conv1_pkg::NUM_FILT; f++) begin
                for (int t = 0; t < conv1_pkg::NUM_TAPS; t++) begin
                    if (hit_c[f][t]) begin
                        weights_o[f][t] <= wght_data_i;
                    end
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- project.f
design/conv1_pkg.sv
design/conv1_ifs.sv
design/conv1_weight_regs.sv
design/conv1_line_buffer.sv
design/conv1_filter_array.sv
design/conv1_max_pool.sv
design/conv1_top.sv
verification/conv1_assertions.sv
verification/conv1_tb.sv

//--- verification/conv1_assertions.sv
// conv1_assertions: reset, spacing and latency properties of the pool strobe, bound to conv1_top
`default_nettype none

module conv1_assertions (
    input logic clk_i,
    input logic reset_i,
    input logic pixel_valid_i,
    input logic sof_i,
    input logic pool_valid_o
);

    // shadow raster position, sof restarts it
    conv1_pkg::coord_t row_q;
    conv1_pkg::coord_t col_q;
    conv1_pkg::coord_t row_c;
    conv1_pkg::coord_t col_c;
    logic              closes_c;

    always_comb begin
        row_c    = sof_i ? '0 : row_q;
        col_c    = sof_i ? '0 : col_q;
        // pixel that completes an odd-row, odd-column map block
        closes_c = pixel_valid_i && row_c[0] && col_c[0] && (row_c >= 3) && (col_c >= 3);
    end

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            row_q <= '0;
            col_q <= '0;
        end else if (pixel_valid_i) begin
            if (col_c == conv1_pkg::coord_t'(conv1_pkg::FRAME_W - 1)) begin
                col_q <= '0;
                row_q <= (row_c == conv1_pkg::coord_t'(conv1_pkg::FRAME_H - 1)) ? '0 : row_c + 1'b1;
            end else begin
                col_q <= col_c + 1'b1;
                row_q <= row_c;
            end
        end
    end

    // strobe held low while reset is applied
    assert property (@(posedge clk_i) reset_i && $past(reset_i) |-> !pool_valid_o)
        else $error("pool_valid_o high during reset");

    assert property (@(posedge clk_i) disable iff (reset_i) pool_valid_o |=> !pool_valid_o)
        else $error("pool_valid_o high on two consecutive cycles");

    // fixed four-cycle latency, both directions
    assert property (@(posedge clk_i) disable iff (reset_i) closes_c |-> ##4 pool_valid_o)
        else $error("pool_valid_o missing four cycles after a block-closing pixel");

    assert property (@(posedge clk_i) disable iff (reset_i) pool_valid_o |-> $past(closes_c, 4))
        else $error("pool_valid_o without a block-closing pixel four cycles before");

endmodule

bind conv1_top conv1_assertions conv1_assertions_inst (
    .clk_i          (clk_i),
    .reset_i        (reset_i),
    .pixel_valid_i  (pixel_valid_i),
    .sof_i          (sof_i),
    .pool_valid_o   (pool_valid_o)
);

`default_nettype wire

//--- verification/conv1_tb.sv
// test table, reference model, result monitor, value checks and watchdog for conv1_top
`default_nettype none

module conv1_tb;

    localparam int CLK_PERIOD = 40;
    localparam int NUM_TESTS  = 5;
    localparam int SEED       = 53187;
    localparam int NPIX       = conv1_pkg::FRAME_W * conv1_pkg::FRAME_H;
    localparam int NPOOL      = conv1_pkg::POOL_W * conv1_pkg::POOL_W;
    localparam int ACT_W      = $bits(conv1_pkg::act_t);
    // weight patterns
    localparam int W_IDENT    = 0;
    localparam int W_NEG      = 1;
    localparam int W_RAND     = 2;
    // pixel patterns
    localparam int P_RAMP     = 0;
    localparam int P_RAND     = 1;

    logic                                       clk_i;
    logic                                       reset_i;
    logic                                       pixel_valid_i;
    conv1_pkg::pixel_t                          pixel_i;
    logic                                       sof_i;
    logic                                       wght_we_i;
    conv1_pkg::wght_addr_t                      wght_addr_i;
    conv1_pkg::weight_t                         wght_data_i;
    logic                                       pool_valid_o;
    conv1_pkg::act_t [conv1_pkg::NUM_FILT-1:0]  pool_data_o;

    // test table as one array per column
    string       name_tab  [NUM_TESTS];
    int          wmode_tab [NUM_TESTS];
    int          pmode_tab [NUM_TESTS];
    bit          gap_tab   [NUM_TESTS];
    bit          trunc_tab [NUM_TESTS];

    // reference model state
    int          img      [NPIX];
    int          wgt      [conv1_pkg::NUM_FILT][conv1_pkg::NUM_TAPS];
    int          expected [NPOOL][conv1_pkg::NUM_FILT];
    logic [conv1_pkg::NUM_FILT*ACT_W-1:0] got_q [$];
    int          errors;
    int          checks;
    int unsigned rand_state;
    int unsigned gap_state;

    conv1_top conv1_top_inst (
        .clk_i          (clk_i),
        .reset_i        (reset_i),
        .pixel_valid_i  (pixel_valid_i),
        .pixel_i        (pixel_i),
        .sof_i          (sof_i),
        .wght_we_i      (wght_we_i),
        .wght_addr_i    (wght_addr_i),
        .wght_data_i    (wght_data_i),
        .pool_valid_o   (pool_valid_o),
        .pool_data_o    (pool_data_o)
    );

    initial clk_i = 1'b0;
    always #(CLK_PERIOD / 2) clk_i = ~clk_i;

    // LCG step returns one byte from the middle bits
    function automatic int rand_byte(inout int unsigned state);
        state = state * 32'd1103515245 + 32'd12345;
        return int'(state[23:16]);
    endfunction

    // capture results mid-cycle on the falling edge
    always @(negedge clk_i) begin
        if (pool_valid_o) begin
            if (reset_i) begin
                errors++;
                $display("a pool result strobe appeared while reset was asserted");
            end
            got_q.push_back(pool_data_o);
        end
    end

    task automatic next_cycle();
        @(posedge clk_i);
        #2;
    endtask

    task automatic check_value(input string test, input string what, input int exp_v,
                               input int act_v);
        checks++;
        if (exp_v != act_v) begin
            errors++;
            $display("error: %s %s expected %0d actual %0d", test, what, exp_v, act_v);
        end
    endtask

    task automatic set_row(input int idx, input string name, input int wmode, input int pmode,
                           input bit gaps, input bit trunc);
        name_tab[idx]  = name;
        wmode_tab[idx] = wmode;
        pmode_tab[idx] = pmode;
        gap_tab[idx]   = gaps;
        trunc_tab[idx] = trunc;
    endtask

    // fill the model's kernels and write them through the weight port
    task automatic load_weights(input int mode);
        int v;
        for (int f = 0; f < conv1_pkg::NUM_FILT; f++) begin
            for (int t = 0; t < conv1_pkg::NUM_TAPS; t++) begin
                case (mode)
                    // centre tap only with filter 1 doubled
                    W_IDENT: v = (t == 4) ? f + 1 : 0;
                    W_NEG:   v = -1 - ((f * conv1_pkg::NUM_TAPS + t) % 7);
                    default: begin
                        v = rand_byte(rand_state);
                        v = (v > 127) ? v - 256 : v;
                    end
                endcase
                wgt[f][t]   = v;
                wght_we_i   = 1'b1;
                wght_addr_i = conv1_pkg::wght_addr_t'(f * conv1_pkg::NUM_TAPS + t);
                wght_data_i = conv1_pkg::weight_t'(v);
                next_cycle();
            end
        end
        wght_we_i = 1'b0;
    endtask

    task automatic make_pixels(input int mode);
        for (int p = 0; p < NPIX; p++) begin
            // ramp starts at 1 so no pixel is zero
            img[p] = (mode == P_RAMP) ? p + 1 : rand_byte(rand_state);
        end
    endtask

    // rectified 3x3 sums followed by 2x2 stride-2 maxima
    task automatic compute_model();
        int conv [conv1_pkg::CONV_W][conv1_pkg::CONV_W];
        int s;
        for (int f = 0; f < conv1_pkg::NUM_FILT; f++) begin
            for (int mr = 0; mr < conv1_pkg::CONV_W; mr++) begin
                for (int mc = 0; mc < conv1_pkg::CONV_W; mc++) begin
                    s = 0;
                    for (int kr = 0; kr < conv1_pkg::KERNEL; kr++) begin
                        for (int kc = 0; kc < conv1_pkg::KERNEL; kc++) begin
                            s += img[(mr + kr) * conv1_pkg::FRAME_W + mc + kc] *
                                 wgt[f][kr * conv1_pkg::KERNEL + kc];
                        end
                    end
                    conv[mr][mc] = (s < 0) ? 0 : s;
                end
            end
            for (int i = 0; i < conv1_pkg::POOL_W; i++) begin
                for (int j = 0; j < conv1_pkg::POOL_W; j++) begin
                    s = 0;
                    for (int d = 0; d < 4; d++) begin
                        if (conv[2*i + d/2][2*j + d%2] > s) begin
                            s = conv[2*i + d/2][2*j + d%2];
                        end
                    end
                    expected[i * conv1_pkg::POOL_W + j][f] = s;
                end
            end
        end
    endtask

    // first pixel carries sof
    // optional idle cycle before each strobe
    task automatic stream_frame(input int count, input bit gaps);
        for (int p = 0; p < count; p++) begin
            if (gaps) begin
                repeat (rand_byte(gap_state) % 2) next_cycle();
            end
            pixel_valid_i = 1'b1;
            pixel_i       = conv1_pkg::pixel_t'(img[p]);
            sof_i         = (p == 0);
            next_cycle();
            pixel_valid_i = 1'b0;
            sof_i         = 1'b0;
        end
    endtask

    task automatic run_test(input int idx);
        int n_trunc;
        int waited;
        int err_start;
        int chk_start;
        n_trunc    = 0;
        waited     = 0;
        err_start  = errors;
        chk_start  = checks;
        // random tests restart the LCG and share one frame
        rand_state = SEED;
        load_weights(wmode_tab[idx]);
        make_pixels(pmode_tab[idx]);
        compute_model();
        got_q.delete();
        if (trunc_tab[idx]) begin
            // cut-short frame ends at image position (4,4)
            stream_frame(NPIX / 2 + 5, gap_tab[idx]);
            repeat (8) next_cycle();
            n_trunc = got_q.size();
            got_q.delete();
        end
        stream_frame(NPIX, gap_tab[idx]);
        while (got_q.size() < NPOOL && waited < 20) begin
            next_cycle();
            waited++;
        end
        // a few more cycles to catch extra strobes
        repeat (6) next_cycle();
        check_value(name_tab[idx], "result count", NPOOL, got_q.size());
        for (int i = 0; i < NPOOL && i < got_q.size(); i++) begin
            for (int f = 0; f < conv1_pkg::NUM_FILT; f++) begin
                check_value(name_tab[idx], $sformatf("result %0d filter %0d", i, f),
                            expected[i][f], int'(got_q[i][f*ACT_W +: ACT_W]));
            end
        end
        $display("test %s: %0d checks, %0d errors, %0d unchecked results", name_tab[idx],
                 checks - chk_start, errors - err_start, n_trunc);
    endtask

    // watchdog allows 200 cycles per table entry
    initial begin
        #(NUM_TESTS * 200 * CLK_PERIOD);
        $display("watchdog expired before the test table finished");
        $display("Testbench failed");
        $finish;
    end

    initial begin
        errors        = 0;
        checks        = 0;
        rand_state    = SEED;
        gap_state     = SEED;
        reset_i       = 1'b1;
        pixel_valid_i = 1'b0;
        pixel_i       = '0;
        sof_i         = 1'b0;
        wght_we_i     = 1'b0;
        wght_addr_i   = '0;
        wght_data_i   = '0;
        set_row(0, "identity_centre", W_IDENT, P_RAND, 1'b0, 1'b0);
        set_row(1, "negative_clamp",  W_NEG,   P_RAMP, 1'b0, 1'b0);
        set_row(2, "random_frame",    W_RAND,  P_RAND, 1'b0, 1'b0);
        set_row(3, "random_gaps",     W_RAND,  P_RAND, 1'b1, 1'b0);
        set_row(4, "truncated_sof",   W_RAND,  P_RAND, 1'b0, 1'b1);
        repeat (5) @(posedge clk_i);
        #2;
        reset_i = 1'b0;
        // nothing may come out right after reset
        repeat (4) next_cycle();
        check_value("after_reset", "result count", 0, got_q.size());
        for (int idx = 0; idx < NUM_TESTS; idx++) begin
            run_test(idx);
        end
        $display("summary: %0d tests, %0d checks, %0d errors", NUM_TESTS, checks, errors);
        if (errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
